//--- wcache_defines.svh
// Weight cache sizing constants shared by RTL and testbench
`ifndef WCACHE_DEFINES_SVH
`define WCACHE_DEFINES_SVH

// ====================
// Port side
// ====================
`define WCACHE_PORTS    4    // PE ports
`define WCACHE_PORT_W   2    // Port index width

// ====================
// Weight RAM side
// ====================
`define WCACHE_ADDR_W   13
`define WCACHE_DATA_W   8

// ====================
// Cache table
// ====================
`define WCACHE_ENTRIES  8    // Fully associative entries
`define WCACHE_ENTRY_W  3    // Entry index width

`endif

//--- wcache_pkg.sv
// Weight cache package with FSM state, mode opcode and width types
`default_nettype none

`include "wcache_defines.svh"

package wcache_pkg;

    // Control FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        CFG  = 2'd1,
        WORK = 2'd2
    } wcache_state_e;

    // Configuration opcode
    typedef enum logic {
        MODE_BYPASS = 1'b0,  // Every request reads the RAM
        MODE_CACHE  = 1'b1   // Repeated addresses served from the table
    } wcache_mode_e;

    typedef logic [`WCACHE_ADDR_W-1:0] addr_t;
    typedef logic [`WCACHE_DATA_W-1:0] data_t;
    typedef logic [`WCACHE_PORT_W-1:0] port_id_t;

endpackage

`default_nettype wire

//--- wcache_ctrl.sv
// Weight cache control FSM holding the configured mode
`default_nettype none

`include "wcache_defines.svh"

module wcache_ctrl
    import wcache_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cfg_valid,
    input  wcache_mode_e cfg_mode,
    output logic         cfg_ready,
    output logic         working,
    output wcache_mode_e mode
);

    wcache_state_e state;
    wcache_state_e next_state;

    // ====================
    // State machine
    // ====================
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (cfg_valid) next_state = CFG;
            CFG:     next_state = WORK;           // One settling cycle
            WORK:    if (cfg_valid) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Mode is taken at the configuration transfer only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_BYPASS;
        end else if (cfg_valid && cfg_ready) begin
            mode <= cfg_mode;
        end
    end

    assign cfg_ready = (state == IDLE);
    assign working   = (state == WORK);

endmodule

`default_nettype wire

//--- wcache_port_arb.sv
// Port acceptance and round-robin arbitration of misses onto the RAM address channel
`default_nettype none

`include "wcache_defines.svh"

module wcache_port_arb
    import wcache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        working,
    input  wcache_mode_e                mode,
    input  logic [`WCACHE_PORTS-1:0]    req_valid,
    input  logic [`WCACHE_PORTS-1:0]    req_last,
    input  addr_t [`WCACHE_PORTS-1:0]   req_addr,
    input  logic [`WCACHE_PORTS-1:0]    hit,
    input  logic [`WCACHE_PORTS-1:0]    rsp_done,
    output logic [`WCACHE_PORTS-1:0]    req_ready,
    output logic [`WCACHE_PORTS-1:0]    hit_push,
    output logic                        wram_addr_valid,
    input  logic                        wram_addr_ready,
    output addr_t                       wram_addr,
    output logic                        issue_valid,
    output port_id_t                    issue_port,
    output logic                        issue_last
);

    logic [`WCACHE_PORTS-1:0] busy;       // One outstanding request per port
    logic [`WCACHE_PORTS-1:0] eff_hit;
    logic [`WCACHE_PORTS-1:0] miss_req;
    port_id_t                 rr_ptr;
    port_id_t                 grant;
    logic                     rr_found;
    port_id_t                 rr_port;
    logic                     lock_valid;  // Address offered but not yet taken
    port_id_t                 lock_port;

    // ====================
    // Hit / miss split
    // ====================
    // A port already offered to the RAM stays a miss even if a fill makes it hit
    always_comb begin
        for (int p = 0; p < `WCACHE_PORTS; p++) begin
            eff_hit[p]  = hit[p] && (mode == MODE_CACHE) &&
                          !(lock_valid && lock_port == port_id_t'(p));
            hit_push[p] = working && req_valid[p] && !busy[p] && eff_hit[p];
            miss_req[p] = working && req_valid[p] && !busy[p] && !eff_hit[p];
        end
    end

    // Round-robin search starting at rr_ptr
    always_comb begin
        port_id_t cand;
        rr_found = 1'b0;
        rr_port  = rr_ptr;
        for (int i = 0; i < `WCACHE_PORTS; i++) begin
            cand = port_id_t'(rr_ptr + i);
            if (!rr_found && miss_req[cand]) begin
                rr_found = 1'b1;
                rr_port  = cand;
            end
        end
    end

    assign grant           = lock_valid ? lock_port : rr_port;
    assign wram_addr_valid = lock_valid ? miss_req[lock_port] : rr_found;
    assign wram_addr       = req_addr[grant];

    assign issue_valid = wram_addr_valid && wram_addr_ready;  // RAM took it
    assign issue_port  = grant;
    assign issue_last  = req_last[grant];

    always_comb begin
        for (int p = 0; p < `WCACHE_PORTS; p++) begin
            req_ready[p] = hit_push[p] || (issue_valid && grant == port_id_t'(p));
        end
    end

    // ====================
    // Registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else if (!working) begin
            busy <= '0;
        end else begin
            for (int p = 0; p < `WCACHE_PORTS; p++) begin
                if (req_valid[p] && req_ready[p]) begin
                    busy[p] <= 1'b1;
                end else if (rsp_done[p]) begin
                    busy[p] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr     <= '0;
            lock_valid <= 1'b0;
            lock_port  <= '0;
        end else begin
            if (issue_valid) rr_ptr <= grant + 1'b1;  // Move past the winner
            lock_valid <= wram_addr_valid && !wram_addr_ready;
            if (wram_addr_valid) lock_port <= grant;
        end
    end

endmodule

`default_nettype wire

//--- wcache_weight_store.sv
// Fully associative weight table with per-port lookup and round-robin fill
`default_nettype none

`include "wcache_defines.svh"

module wcache_weight_store
    import wcache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        working,
    input  wcache_mode_e                mode,
    input  addr_t [`WCACHE_PORTS-1:0]   req_addr,
    output logic [`WCACHE_PORTS-1:0]    hit,
    output data_t [`WCACHE_PORTS-1:0]   hit_data,
    input  logic                        fill_valid,
    input  addr_t                       fill_addr,
    input  data_t                       fill_data
);

    typedef logic [`WCACHE_ENTRY_W-1:0] entry_t;

    localparam int LAST_ENTRY = `WCACHE_ENTRIES - 1;

    addr_t                      tag  [`WCACHE_ENTRIES];
    data_t                      data [`WCACHE_ENTRIES];
    logic [`WCACHE_ENTRIES-1:0] valid;
    entry_t                     fill_ptr;    // Oldest entry, next to be replaced
    logic                       lookup_en;
    logic                       fill_present;
    logic                       fill_write;

    assign lookup_en = working && (mode == MODE_CACHE);

    // ====================
    // Lookup
    // ====================
    always_comb begin
        for (int p = 0; p < `WCACHE_PORTS; p++) begin
            hit[p]      = 1'b0;
            hit_data[p] = '0;
            for (int e = 0; e < `WCACHE_ENTRIES; e++) begin
                if (lookup_en && valid[e] && tag[e] == req_addr[p]) begin
                    hit[p]      = 1'b1;
                    hit_data[p] = data[e];
                end
            end
        end
    end

    // Skip fills for addresses already held
    always_comb begin
        fill_present = 1'b0;
        for (int e = 0; e < `WCACHE_ENTRIES; e++) begin
            if (valid[e] && tag[e] == fill_addr) fill_present = 1'b1;
        end
    end

    assign fill_write = fill_valid && lookup_en && !fill_present;

    // ====================
    // Fill
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid    <= '0;
            fill_ptr <= '0;
        end else if (!working) begin
            valid    <= '0;                 // Flush
            fill_ptr <= '0;
        end else if (fill_write) begin
            valid[fill_ptr] <= 1'b1;
            if (fill_ptr == entry_t'(LAST_ENTRY)) begin
                fill_ptr <= '0;
            end else begin
                fill_ptr <= fill_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_write) begin
            tag[fill_ptr]  <= fill_addr;
            data[fill_ptr] <= fill_data;
        end
    end

endmodule

`default_nettype wire

//--- wcache_rsp_return.sv
// Response return path with in-flight port FIFO, hit registers and output steering
`default_nettype none

`include "wcache_defines.svh"

module wcache_rsp_return
    import wcache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        working,
    input  logic [`WCACHE_PORTS-1:0]    hit_push,
    input  data_t [`WCACHE_PORTS-1:0]   hit_data,
    input  logic [`WCACHE_PORTS-1:0]    req_last,
    input  logic                        issue_valid,
    input  port_id_t                    issue_port,
    input  logic                        issue_last,
    input  logic                        wram_data_valid,
    output logic                        wram_data_ready,
    input  data_t                       wram_data,
    input  addr_t                       req_addr_issued,
    output logic [`WCACHE_PORTS-1:0]    rsp_valid,
    output logic [`WCACHE_PORTS-1:0]    rsp_last,
    output data_t [`WCACHE_PORTS-1:0]   rsp_data,
    input  logic [`WCACHE_PORTS-1:0]    rsp_ready,
    output logic [`WCACHE_PORTS-1:0]    rsp_done,
    output logic                        fill_valid,
    output addr_t                       fill_addr,
    output data_t                       fill_data
);

    // ====================
    // In-flight FIFO
    // ====================
    port_id_t                 fifo_port [`WCACHE_PORTS];
    logic                     fifo_last [`WCACHE_PORTS];
    addr_t                    fifo_addr [`WCACHE_PORTS];
    port_id_t                 wr_ptr;
    port_id_t                 rd_ptr;
    logic [`WCACHE_PORT_W:0]  count;     // Never exceeds the port count
    logic                     fifo_empty;
    port_id_t                 head_port;
    logic                     ram_pop;

    // Hit registers
    logic [`WCACHE_PORTS-1:0] hit_vld;
    logic [`WCACHE_PORTS-1:0] hit_lst;
    data_t                    hit_dat [`WCACHE_PORTS];

    assign fifo_empty      = (count == '0);
    assign head_port       = fifo_port[rd_ptr];
    assign wram_data_ready = !fifo_empty && rsp_ready[head_port];  // Stall RAM with the PE
    assign ram_pop         = wram_data_valid && wram_data_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (issue_valid) wr_ptr <= wr_ptr + 1'b1;
            if (ram_pop)     rd_ptr <= rd_ptr + 1'b1;
            case ({issue_valid, ram_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            fifo_port[wr_ptr] <= issue_port;
            fifo_last[wr_ptr] <= issue_last;
            fifo_addr[wr_ptr] <= req_addr_issued;
        end
    end

    // ====================
    // Hit path
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_vld <= '0;
        end else begin
            for (int p = 0; p < `WCACHE_PORTS; p++) begin
                if (!working) begin
                    hit_vld[p] <= 1'b0;
                end else if (hit_push[p]) begin
                    hit_vld[p] <= 1'b1;
                end else if (rsp_ready[p]) begin
                    hit_vld[p] <= 1'b0;   // Taken, or nothing held
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `WCACHE_PORTS; p++) begin
            if (hit_push[p]) begin
                hit_dat[p] <= hit_data[p];
                hit_lst[p] <= req_last[p];
            end
        end
    end

    // Only one source can hold a port's outstanding item
    always_comb begin
        for (int p = 0; p < `WCACHE_PORTS; p++) begin
            if (hit_vld[p]) begin
                rsp_valid[p] = 1'b1;
                rsp_data[p]  = hit_dat[p];
                rsp_last[p]  = hit_lst[p];
            end else begin
                rsp_valid[p] = wram_data_valid && !fifo_empty &&
                               head_port == port_id_t'(p);
                rsp_data[p]  = wram_data;
                rsp_last[p]  = fifo_last[rd_ptr];
            end
            rsp_done[p] = rsp_valid[p] && rsp_ready[p];
        end
    end

    assign fill_valid = ram_pop;          // One pulse per RAM return
    assign fill_addr  = fifo_addr[rd_ptr];
    assign fill_data  = wram_data;

endmodule

`default_nettype wire

//--- wcache_top.sv
// Weight cache top level between PE ports and the weight RAM read channel
`default_nettype none

`include "wcache_defines.svh"

module wcache_top
    import wcache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    // Configuration
    input  logic                        cfg_valid,
    output logic                        cfg_ready,
    input  wcache_mode_e                cfg_mode,
    // Port requests
    input  logic [`WCACHE_PORTS-1:0]    req_valid,
    output logic [`WCACHE_PORTS-1:0]    req_ready,
    input  addr_t [`WCACHE_PORTS-1:0]   req_addr,
    input  logic [`WCACHE_PORTS-1:0]    req_last,
    // Port responses
    output logic [`WCACHE_PORTS-1:0]    rsp_valid,
    input  logic [`WCACHE_PORTS-1:0]    rsp_ready,
    output data_t [`WCACHE_PORTS-1:0]   rsp_data,
    output logic [`WCACHE_PORTS-1:0]    rsp_last,
    // Weight RAM
    output logic                        wram_addr_valid,
    input  logic                        wram_addr_ready,
    output addr_t                       wram_addr,
    input  logic                        wram_data_valid,
    output logic                        wram_data_ready,
    input  data_t                       wram_data
);

    logic                     working;
    wcache_mode_e             mode;
    logic [`WCACHE_PORTS-1:0] hit;
    data_t [`WCACHE_PORTS-1:0] hit_data;
    logic [`WCACHE_PORTS-1:0] hit_push;
    logic [`WCACHE_PORTS-1:0] rsp_done;
    logic                     issue_valid;
    port_id_t                 issue_port;
    logic                     issue_last;
    logic                     fill_valid;
    addr_t                    fill_addr;
    data_t                    fill_data;

    wcache_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .cfg_valid(cfg_valid), .cfg_mode(cfg_mode), .cfg_ready(cfg_ready),
        .working(working), .mode(mode)
    );

    wcache_port_arb u_port_arb (
        .clk(clk), .rst_n(rst_n), .working(working), .mode(mode),
        .req_valid(req_valid), .req_last(req_last), .req_addr(req_addr),
        .hit(hit), .rsp_done(rsp_done), .req_ready(req_ready), .hit_push(hit_push),
        .wram_addr_valid(wram_addr_valid), .wram_addr_ready(wram_addr_ready),
        .wram_addr(wram_addr),
        .issue_valid(issue_valid), .issue_port(issue_port), .issue_last(issue_last)
    );

    wcache_weight_store u_store (
        .clk(clk), .rst_n(rst_n), .working(working), .mode(mode),
        .req_addr(req_addr), .hit(hit), .hit_data(hit_data),
        .fill_valid(fill_valid), .fill_addr(fill_addr), .fill_data(fill_data)
    );

    wcache_rsp_return u_rsp (
        .clk(clk), .rst_n(rst_n), .working(working),
        .hit_push(hit_push), .hit_data(hit_data), .req_last(req_last),
        .issue_valid(issue_valid), .issue_port(issue_port), .issue_last(issue_last),
        .wram_data_valid(wram_data_valid), .wram_data_ready(wram_data_ready),
        .wram_data(wram_data), .req_addr_issued(wram_addr),
        .rsp_valid(rsp_valid), .rsp_last(rsp_last), .rsp_data(rsp_data),
        .rsp_ready(rsp_ready), .rsp_done(rsp_done),
        .fill_valid(fill_valid), .fill_addr(fill_addr), .fill_data(fill_data)
    );

endmodule

`default_nettype wire

//--- wcache_asserts.sv
// Handshake assertions for the weight cache, bound into the top level
`default_nettype none

`include "wcache_defines.svh"

module wcache_asserts
    import wcache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        working,
    input  logic [`WCACHE_PORTS-1:0]    req_ready,
    input  logic [`WCACHE_PORTS-1:0]    rsp_valid,
    input  logic [`WCACHE_PORTS-1:0]    rsp_ready,
    input  data_t [`WCACHE_PORTS-1:0]   rsp_data,
    input  logic                        wram_addr_valid,
    input  logic                        wram_addr_ready,
    input  addr_t                       wram_addr
);

    int fail_count = 0;

    // ====================
    // Response hold
    // ====================
    for (genvar p = 0; p < `WCACHE_PORTS; p++) begin : g_port
        rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_valid[p] && !rsp_ready[p] |=> rsp_valid[p] && $stable(rsp_data[p]))
        else begin
            $error("Port %0d response dropped or changed while stalled", p);
            fail_count++;
        end
    end

    // Address stays offered until the RAM takes it
    addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wram_addr_valid && !wram_addr_ready |=> wram_addr_valid && $stable(wram_addr))
    else begin
        $error("RAM address withdrawn or changed before acceptance");
        fail_count++;
    end

    ready_in_work: assert property (@(posedge clk) disable iff (!rst_n)
        !working |-> req_ready == '0)
    else begin
        $error("Request accepted while not in WORK");
        fail_count++;
    end

endmodule

bind wcache_top wcache_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .working(working), .req_ready(req_ready),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data),
    .wram_addr_valid(wram_addr_valid), .wram_addr_ready(wram_addr_ready),
    .wram_addr(wram_addr)
);

`default_nettype wire

//--- tb.sv
// Directed testbench for the weight cache with a weight RAM model
`default_nettype none

`include "wcache_defines.svh"

module tb
    import wcache_pkg::*;
();

    localparam int WAIT_LIMIT = 200;   // Cycles per wait loop

    logic                        clk;
    logic                        rst_n;
    logic                        cfg_valid;
    logic                        cfg_ready;
    wcache_mode_e                cfg_mode;
    logic [`WCACHE_PORTS-1:0]    req_valid;
    logic [`WCACHE_PORTS-1:0]    req_ready;
    addr_t [`WCACHE_PORTS-1:0]   req_addr;
    logic [`WCACHE_PORTS-1:0]    req_last;
    logic [`WCACHE_PORTS-1:0]    rsp_valid;
    logic [`WCACHE_PORTS-1:0]    rsp_ready;
    data_t [`WCACHE_PORTS-1:0]   rsp_data;
    logic [`WCACHE_PORTS-1:0]    rsp_last;
    logic                        wram_addr_valid;
    logic                        wram_addr_ready;
    addr_t                       wram_addr;
    logic                        wram_data_valid;
    logic                        wram_data_ready;
    data_t                       wram_data;

    logic [15:0] lfsr = 16'd33;
    int          errors = 0;
    int          ram_reads = 0;      // Accepted RAM addresses
    addr_t       ram_q[$];           // Addresses awaiting data
    logic [1:0]  ram_wait;

    wcache_top UUT (
        .clk(clk), .rst_n(rst_n),
        .cfg_valid(cfg_valid), .cfg_ready(cfg_ready), .cfg_mode(cfg_mode),
        .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
        .req_last(req_last),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data),
        .rsp_last(rsp_last),
        .wram_addr_valid(wram_addr_valid), .wram_addr_ready(wram_addr_ready),
        .wram_addr(wram_addr),
        .wram_data_valid(wram_data_valid), .wram_data_ready(wram_data_ready),
        .wram_data(wram_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================
    // Fibonacci taps x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[14:0], fb};
        end
        return v;
    endfunction

    function automatic data_t weight_of(input addr_t a);
        return a[7:0] ^ 8'h5A;          // RAM contents
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic finish_run;
        $display("Run complete: %0d check errors, %0d assertion failures",
                 errors, UUT.u_asserts.fail_count);
        if (errors == 0 && UUT.u_asserts.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        finish_run();
    endtask

    // ====================
    // RAM model
    // ====================
    initial begin : ram_model
        bit    a_take;
        bit    d_take;
        addr_t a_val;
        wram_addr_ready = 1'b0;
        wram_data_valid = 1'b0;
        wram_data       = '0;
        ram_wait        = '0;
        forever begin
            @(negedge clk);             // Handshakes settle mid cycle
            a_take = wram_addr_valid && wram_addr_ready;
            d_take = wram_data_valid && wram_data_ready;
            a_val  = wram_addr;
            @(posedge clk);
            #1;
            if (a_take) begin
                ram_q.push_back(a_val);
                ram_reads++;
            end
            if (d_take) begin
                void'(ram_q.pop_front());
                ram_wait = 2'(rand_bits(2));   // Latency of the next word
            end else if (ram_wait != 0) begin
                ram_wait--;
            end
            if (ram_q.size() != 0 && ram_wait == 0) begin
                wram_data_valid = 1'b1;
                wram_data       = weight_of(ram_q[0]);
            end else begin
                wram_data_valid = 1'b0;
                wram_data       = '0;
            end
            wram_addr_ready = (rand_bits(2) != 0);
        end
    end

    // ====================
    // Port and config drivers
    // ====================
    task automatic access(input int p, input addr_t addr, input logic last,
                          input bit use_bp, input bit one_cycle, input string name);
        bit    done;
        data_t got_data;
        logic  got_last;
        string tag;
        tag          = $sformatf("%s port %0d", name, p);
        req_valid[p] = 1'b1;
        req_addr[p]  = addr;
        req_last[p]  = last;
        done         = 1'b0;
        for (int t = 0; t < WAIT_LIMIT && !done; t++) begin
            @(negedge clk);
            done = req_ready[p];
            @(posedge clk);
            #1;
        end
        if (!done) report_timeout({tag, " request acceptance"});
        req_valid[p] = 1'b0;
        done         = 1'b0;
        for (int t = 0; t < WAIT_LIMIT && !done; t++) begin
            rsp_ready[p] = use_bp ? (rand_bits(2) != 0) : 1'b1;
            @(negedge clk);
            if (one_cycle && t == 0) compare({tag, " hit latency"}, 1, rsp_valid[p]);
            done     = rsp_valid[p] && rsp_ready[p];
            got_data = rsp_data[p];
            got_last = rsp_last[p];
            @(posedge clk);
            #1;
        end
        if (!done) report_timeout({tag, " response"});
        rsp_ready[p] = 1'b0;
        compare({tag, " data"}, weight_of(addr), got_data);
        compare({tag, " last"}, last, got_last);
    endtask

    // Addresses from base up to base + 7 so repeats are common
    task automatic port_stream(input int p, input int n, input addr_t base,
                               input bit use_bp, input string name);
        addr_t a;
        logic  l;
        for (int i = 0; i < n; i++) begin
            a = base + addr_t'(rand_bits(3));
            l = rand_bits(1) != 0;
            access(p, a, l, use_bp, 1'b0, name);
        end
    endtask

    // From WORK the FSM passes IDLE first and flushes the table
    task automatic configure(input wcache_mode_e m, input string name);
        bit done;
        cfg_mode  = m;
        cfg_valid = 1'b1;
        done      = 1'b0;
        for (int t = 0; t < WAIT_LIMIT && !done; t++) begin
            @(negedge clk);
            done = cfg_ready;
            @(posedge clk);
            #1;
        end
        if (!done) report_timeout({name, " configuration handshake"});
        cfg_valid = 1'b0;
        @(negedge clk);                 // CFG cycle
        compare({name, " working in CFG"}, 0, UUT.working);
        @(posedge clk);
        #1;
        @(negedge clk);
        compare({name, " working"}, 1, UUT.working);
        @(posedge clk);
        #1;
    endtask

    // ====================
    // Tests
    // ====================
    task automatic reset_state;
        @(negedge clk);
        compare("reset cfg_ready", 1, cfg_ready);
        compare("reset rsp_valid", 0, rsp_valid);
        compare("reset req_ready", 0, req_ready);
        compare("reset wram_addr_valid", 0, wram_addr_valid);
        compare("reset wram_data_ready", 0, wram_data_ready);
        @(posedge clk);
        #1;
        req_valid = '1;                 // IDLE refuses requests
        @(negedge clk);
        compare("reset idle req_ready", 0, req_ready);
        @(posedge clk);
        #1;
        req_valid = '0;
    endtask

    task automatic bypass_reads;
        int r0;
        configure(MODE_BYPASS, "bypass");
        r0 = ram_reads;
        fork
            port_stream(0, 4, 13'h040, 1'b0, "bypass");
            port_stream(1, 4, 13'h040, 1'b0, "bypass");
            port_stream(2, 4, 13'h040, 1'b0, "bypass");
            port_stream(3, 4, 13'h040, 1'b0, "bypass");
        join
        compare("bypass ram reads", 16, ram_reads - r0);
    endtask

    task automatic cache_single_port;
        int    r0;
        addr_t a;
        configure(MODE_CACHE, "cache_single");
        r0 = ram_reads;
        for (int pass = 0; pass < 3; pass++) begin
            for (int i = 0; i < 8; i++) begin
                a = 13'h100 + addr_t'(5 * i);
                access(1, a, i == 7, 1'b0, pass != 0, "cache_single");
            end
        end
        compare("cache_single ram reads", 8, ram_reads - r0);
    endtask

    task automatic cache_all_ports;
        fork
            port_stream(0, 8, 13'h200, 1'b1, "cache_all");
            port_stream(1, 8, 13'h200, 1'b1, "cache_all");
            port_stream(2, 8, 13'h200, 1'b1, "cache_all");
            port_stream(3, 8, 13'h200, 1'b1, "cache_all");
        join
        @(negedge clk);                 // Last RAM word popped by now
        compare("cache_all pending RAM reads", 0, ram_q.size());
        @(posedge clk);
        #1;
    endtask

    task automatic flush_and_replace;
        int r0;
        access(2, 13'h0AA, 1'b0, 1'b0, 1'b0, "flush");
        r0 = ram_reads;
        access(2, 13'h0AA, 1'b1, 1'b0, 1'b1, "flush");
        compare("flush cached before", r0, ram_reads);
        configure(MODE_CACHE, "flush");
        r0 = ram_reads;
        access(2, 13'h0AA, 1'b0, 1'b0, 1'b0, "flush");
        compare("flush reread", r0 + 1, ram_reads);
        for (int i = 1; i <= 8; i++) begin
            access(2, 13'h300 + addr_t'(i), i[0], 1'b0, 1'b0, "replace");
        end
        compare("replace fill reads", r0 + 9, ram_reads);
        access(2, 13'h0AA, 1'b1, 1'b0, 1'b0, "replace");   // Oldest entry gone
        compare("replace first evicted", r0 + 10, ram_reads);
        access(2, 13'h308, 1'b0, 1'b0, 1'b1, "replace");
        compare("replace newest kept", r0 + 10, ram_reads);
    endtask

    initial begin
        rst_n     = 1'b0;
        cfg_valid = 1'b0;
        cfg_mode  = MODE_BYPASS;
        req_valid = '0;
        req_addr  = '0;
        req_last  = '0;
        rsp_ready = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_state();
        bypass_reads();
        cache_single_port();
        cache_all_ports();
        flush_and_replace();
        finish_run();
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
wcache_pkg.sv
wcache_ctrl.sv
wcache_port_arb.sv
wcache_weight_store.sv
wcache_rsp_return.sv
wcache_top.sv
wcache_asserts.sv
tb.sv

//--- Bender.yml
package:
  name: wcache

sources:
  - include_dirs:
      - .
    files:
      - wcache_pkg.sv
      - wcache_ctrl.sv
      - wcache_port_arb.sv
      - wcache_weight_store.sv
      - wcache_rsp_return.sv
      - wcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - wcache_asserts.sv
      - tb.sv
